// ==== verilog/otp_pkg.sv ====
// otp package: ip bus and macro command structs, array sizes and timing constants.
package otp_pkg;

	parameter int OTP_WIDTH         = 32;                          // bits per otp word.
	parameter int OTP_DEPTH_DEFAULT = 64;                          // words in a default part.
	parameter int OTP_ADDR_W        = 16;                          // byte address on the bus.
	parameter int OTP_SEL_W         = OTP_WIDTH / 8;               // one select per byte.
	parameter int OTP_IDX_W         = OTP_ADDR_W - $clog2(OTP_SEL_W); // word index width.

	parameter int READ_CYCLES_NORMAL = 2;                          // array wait, normal read.
	parameter int READ_CYCLES_MARGIN = 6;                          // array wait, margin read.
	parameter int PROG_CYCLES        = 8;                          // program pulse length.

	// strobe/acknowledge ip bus, same layout in both directions.
	typedef struct packed {
		logic [OTP_ADDR_W-1:0] adr;                                // byte address.
		logic [OTP_WIDTH-1:0]  dat;                                // write or read data.
		logic [OTP_SEL_W-1:0]  sel;                                // byte selects.
		logic                  stb;                                // cycle strobe.
		logic                  we;                                 // write enable.
		logic                  ack;                                // cycle acknowledge.
	} t_ip_bus;

	// request from the bus slave to the controller.
	typedef struct packed {
		logic                 rd;                                  // read pulse.
		logic                 pg;                                  // program pulse.
		logic [OTP_IDX_W-1:0] idx;                                 // word index.
		logic [OTP_WIDTH-1:0] wdata;                               // write data.
		logic [OTP_SEL_W-1:0] mask;                                // byte mask.
	} t_otp_req;

	// command from the controller to the array.
	typedef struct packed {
		logic                 rd_en;                               // read strobe.
		logic                 pg_en;                               // program strobe.
		logic [OTP_IDX_W-1:0] idx;                                 // word index.
		logic [OTP_WIDTH-1:0] bits;                                // bits to set.
	} t_otp_cmd;

endpackage

// ==== verilog/otp_bus_slave.sv ====
// otp_bus_slave: ip bus cycle decode, address range check and acknowledge.
module otp_bus_slave #(
	parameter int DEPTH = otp_pkg::OTP_DEPTH_DEFAULT
) (
	input  logic                          i_sys_clk,
	input  logic                          i_rst,
	input  otp_pkg::t_ip_bus              i_ip_bus,
	output otp_pkg::t_ip_bus              o_ip_bus,
	output otp_pkg::t_otp_req             o_req,
	input  logic                          i_done,
	input  logic [otp_pkg::OTP_WIDTH-1:0] i_rdata
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DECODE,
		S_SKIP,
		S_WAIT
	} t_state;

	t_state                          state;
	otp_pkg::t_ip_bus                bus_q;                        // latched bus cycle.
	logic [otp_pkg::OTP_IDX_W-1:0]   word_idx;
	logic [otp_pkg::OTP_WIDTH-1:0]   dat_q;
	logic                            ack_q;
	logic                            req_rd_q;
	logic                            req_pg_q;
	logic                            accept;
	logic                            in_range;

	// new cycle, not in the cycle right after our own ack.
	assign accept   = (state == S_IDLE) && i_ip_bus.stb && !ack_q;
	assign word_idx = bus_q.adr[otp_pkg::OTP_ADDR_W-1:otp_pkg::OTP_ADDR_W-otp_pkg::OTP_IDX_W];
	assign in_range = 32'(word_idx) < DEPTH;

	always_ff @(posedge i_sys_clk) begin
		if (i_rst) begin
			state    <= S_IDLE;
			ack_q    <= 1'b0;
			req_rd_q <= 1'b0;
			req_pg_q <= 1'b0;
		end else begin
			ack_q    <= 1'b0;                                      // ack is a single pulse.
			req_rd_q <= 1'b0;
			req_pg_q <= 1'b0;
			case (state)
				S_IDLE: if (accept) state <= S_DECODE;
				S_DECODE: begin
					if (in_range) begin
						req_rd_q <= !bus_q.we;
						req_pg_q <= bus_q.we;
						state    <= S_WAIT;
					end else begin
						state <= S_SKIP;                           // no array access.
					end
				end
				S_SKIP: begin
					ack_q <= 1'b1;
					state <= S_IDLE;
				end
				S_WAIT: if (i_done) begin
					ack_q <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (accept) bus_q <= i_ip_bus;
		if (state == S_SKIP) dat_q <= '0;                          // out of range reads zero.
		else if (state == S_WAIT && i_done) dat_q <= bus_q.we ? '0 : i_rdata;
	end

	always_comb begin
		o_ip_bus.adr = bus_q.adr;
		o_ip_bus.dat = dat_q;
		o_ip_bus.sel = bus_q.sel;
		o_ip_bus.stb = 1'b0;
		o_ip_bus.we  = bus_q.we;
		o_ip_bus.ack = ack_q;
		o_req.rd     = req_rd_q;
		o_req.pg     = req_pg_q;
		o_req.idx    = word_idx;
		o_req.wdata  = bus_q.dat;
		o_req.mask   = bus_q.sel;
	end

	a_ack_single: assert property (@(posedge i_sys_clk) disable iff (i_rst)
		o_ip_bus.ack |=> !o_ip_bus.ack);

endmodule

// ==== verilog/otp_ctrl.sv ====
// otp_ctrl: read and program sequencer with sleep hold and margin read timing.
module otp_ctrl #(
	parameter int DEPTH              = otp_pkg::OTP_DEPTH_DEFAULT,
	parameter int READ_CYCLES_NORMAL = otp_pkg::READ_CYCLES_NORMAL,
	parameter int READ_CYCLES_MARGIN = otp_pkg::READ_CYCLES_MARGIN,
	parameter int PROG_CYCLES        = otp_pkg::PROG_CYCLES
) (
	input  logic                          i_sys_clk,
	input  logic                          i_rst,
	input  otp_pkg::t_otp_req             i_req,
	output logic                          o_done,
	output logic [otp_pkg::OTP_WIDTH-1:0] o_rdata,
	input  logic                          i_sleep,
	input  logic                          i_read_mode,
	input  logic                          i_write_lock,
	output otp_pkg::t_otp_cmd             o_cmd,
	input  logic [otp_pkg::OTP_WIDTH-1:0] i_arr_rdata
);

	localparam int RD_MAX  = (READ_CYCLES_MARGIN > READ_CYCLES_NORMAL) ?
		READ_CYCLES_MARGIN : READ_CYCLES_NORMAL;
	localparam int CNT_MAX = (PROG_CYCLES > RD_MAX) ? PROG_CYCLES : RD_MAX;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SLEEP_HOLD,
		S_READ_WAIT,
		S_PROG,
		S_PROG_WAIT,
		S_VERIFY
	} t_state;

	t_state                          state;
	logic [CNT_W-1:0]                cnt;
	logic [CNT_W-1:0]                rd_load;
	logic                            rd_en_q;
	logic                            pg_en_q;
	logic                            done_q;
	logic                            is_pg_q;
	logic [otp_pkg::OTP_IDX_W-1:0]   idx_q;
	logic [otp_pkg::OTP_WIDTH-1:0]   wdata_q;
	logic [otp_pkg::OTP_SEL_W-1:0]   mask_q;
	logic [otp_pkg::OTP_WIDTH-1:0]   bits_q;
	logic [otp_pkg::OTP_WIDTH-1:0]   rdata_q;
	logic [otp_pkg::OTP_WIDTH-1:0]   byte_bits;
	logic [otp_pkg::OTP_WIDTH-1:0]   new_bits;
	logic                            req_valid;
	logic                            rd_last;
	logic                            skip_prog;

	assign req_valid = i_req.rd || i_req.pg;
	// counts load n-1, data is sampled n cycles after rd_en (n of at least 2).
	assign rd_load   = i_read_mode ? CNT_W'(READ_CYCLES_MARGIN - 1) :
		CNT_W'(READ_CYCLES_NORMAL - 1);
	assign rd_last   = (state == S_READ_WAIT) && (cnt == '0);
	assign new_bits  = wdata_q & byte_bits & ~i_arr_rdata;         // only bits not yet set.
	assign skip_prog = i_write_lock || (new_bits == '0);

	always_comb begin
		for (int b = 0; b < otp_pkg::OTP_SEL_W; b++) begin
			byte_bits[b*8 +: 8] = {8{mask_q[b]}};
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_rst) begin
			state   <= S_IDLE;
			cnt     <= '0;
			rd_en_q <= 1'b0;
			pg_en_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			rd_en_q <= 1'b0;
			pg_en_q <= 1'b0;
			done_q  <= 1'b0;
			case (state)
				S_IDLE: if (req_valid) begin
					if (i_sleep) begin
						state <= S_SLEEP_HOLD;                     // macro asleep, hold request.
					end else begin
						rd_en_q <= 1'b1;
						cnt     <= rd_load;
						state   <= S_READ_WAIT;
					end
				end
				S_SLEEP_HOLD: if (!i_sleep) begin
					rd_en_q <= 1'b1;
					cnt     <= rd_load;
					state   <= S_READ_WAIT;
				end
				S_READ_WAIT: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (is_pg_q && !skip_prog) begin
						pg_en_q <= 1'b1;
						state   <= S_PROG;
					end else begin
						done_q <= 1'b1;                            // plain read or nothing to burn.
						state  <= S_IDLE;
					end
				end
				S_PROG: begin
					cnt   <= CNT_W'(PROG_CYCLES - 1);
					state <= S_PROG_WAIT;
				end
				S_PROG_WAIT: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						rd_en_q <= 1'b1;                           // verify read.
						cnt     <= rd_load;
						state   <= S_VERIFY;
					end
				end
				S_VERIFY: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						done_q <= 1'b1;
						state  <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (state == S_IDLE && req_valid) begin
			is_pg_q <= i_req.pg;
			idx_q   <= i_req.idx;
			wdata_q <= i_req.wdata;
			mask_q  <= i_req.mask;
		end
		if (rd_last) bits_q <= new_bits;
		if (rd_last || (state == S_VERIFY && cnt == '0)) rdata_q <= i_arr_rdata;
	end

	always_comb begin
		o_cmd.rd_en = rd_en_q;
		o_cmd.pg_en = pg_en_q;
		o_cmd.idx   = idx_q;
		o_cmd.bits  = bits_q;
	end

	assign o_done  = done_q;
	assign o_rdata = rdata_q;

	a_rd_pg_excl: assert property (@(posedge i_sys_clk) disable iff (i_rst)
		!(o_cmd.rd_en && o_cmd.pg_en));
	// the slave keeps a single request in flight.
	a_req_idle: assert property (@(posedge i_sys_clk) disable iff (i_rst)
		req_valid |-> (state == S_IDLE) && 32'(i_req.idx) < DEPTH);

endmodule

// ==== verilog/otp_array.sv ====
// otp_array: behavioral otp bit array, or-only programming, registered read.
module otp_array #(
	parameter int DEPTH = otp_pkg::OTP_DEPTH_DEFAULT
) (
	input  logic                          i_sys_clk,
	input  logic                          i_rst,
	input  otp_pkg::t_otp_cmd             i_cmd,
	output logic [otp_pkg::OTP_WIDTH-1:0] o_rdata
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [otp_pkg::OTP_WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]                 addr;

	assign addr = i_cmd.idx[AW-1:0];

	// a blank part reads all zeros.
	always_ff @(posedge i_sys_clk) begin
		if (i_rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (i_cmd.pg_en) begin
			mem[addr] <= mem[addr] | i_cmd.bits;                   // fuses only ever blow.
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_cmd.rd_en) o_rdata <= mem[addr];
	end

	a_idx_range: assert property (@(posedge i_sys_clk) disable iff (i_rst)
		(i_cmd.rd_en || i_cmd.pg_en) |-> 32'(i_cmd.idx) < DEPTH);

endmodule

// ==== verilog/otp_top.sv ====
// otp_top: otp wrapper top level with bus slave, controller and bit array.
module otp_top #(
	parameter int DEPTH              = otp_pkg::OTP_DEPTH_DEFAULT,
	parameter int READ_CYCLES_NORMAL = otp_pkg::READ_CYCLES_NORMAL,
	parameter int READ_CYCLES_MARGIN = otp_pkg::READ_CYCLES_MARGIN,
	parameter int PROG_CYCLES        = otp_pkg::PROG_CYCLES
) (
	input  logic             i_sys_clk,
	input  logic             i_rst,
	input  otp_pkg::t_ip_bus i_ip_bus,
	output otp_pkg::t_ip_bus o_ip_bus,
	input  logic             i_sleep,
	input  logic             i_read_mode,                          // high selects margin read.
	input  logic             i_write_lock                          // high blocks programming.
);

	otp_pkg::t_otp_req             req;
	otp_pkg::t_otp_cmd             cmd;
	logic                          done;
	logic [otp_pkg::OTP_WIDTH-1:0] ctrl_rdata;
	logic [otp_pkg::OTP_WIDTH-1:0] arr_rdata;

	otp_bus_slave #(
		.DEPTH (DEPTH)
	) u_bus_slave (
		.i_sys_clk (i_sys_clk),
		.i_rst     (i_rst),
		.i_ip_bus  (i_ip_bus),
		.o_ip_bus  (o_ip_bus),
		.o_req     (req),
		.i_done    (done),
		.i_rdata   (ctrl_rdata)
	);

	otp_ctrl #(
		.DEPTH              (DEPTH),
		.READ_CYCLES_NORMAL (READ_CYCLES_NORMAL),
		.READ_CYCLES_MARGIN (READ_CYCLES_MARGIN),
		.PROG_CYCLES        (PROG_CYCLES)
	) u_ctrl (
		.i_sys_clk    (i_sys_clk),
		.i_rst        (i_rst),
		.i_req        (req),
		.o_done       (done),
		.o_rdata      (ctrl_rdata),
		.i_sleep      (i_sleep),
		.i_read_mode  (i_read_mode),
		.i_write_lock (i_write_lock),
		.o_cmd        (cmd),
		.i_arr_rdata  (arr_rdata)
	);

	otp_array #(
		.DEPTH (DEPTH)
	) u_array (
		.i_sys_clk (i_sys_clk),
		.i_rst     (i_rst),
		.i_cmd     (cmd),
		.o_rdata   (arr_rdata)
	);

endmodule

// ==== test/otp_tb.sv ====
// testbench module otp_tb with clock, bus stimulus, reference model, compare process and watchdog.
module otp_tb;

	localparam int DEPTH          = 64;
	localparam int W              = otp_pkg::OTP_WIDTH;
	localparam int SW             = otp_pkg::OTP_SEL_W;
	localparam int AW             = otp_pkg::OTP_ADDR_W;
	localparam int PERIOD         = 20;
	localparam int N_RAND         = 48;                         // random write/read pairs.
	localparam int N_LOCK         = 8;
	localparam int N_MODE         = 8;
	localparam int SLEEP_CYCLES   = 24;
	localparam int OOR_ACK_CYCLES = 2;                          // stb sample to ack when out of range.
	localparam int WORST_CYCLES   = 40;                         // margin write with program and verify.
	localparam int N_TRANS        = 2 * DEPTH + 2 * N_RAND + 2 * N_LOCK + 2 * N_MODE + 16;
	localparam int WATCHDOG_TIME  = (N_TRANS * WORST_CYCLES + 2 * SLEEP_CYCLES + 50) * PERIOD;

	logic             i_sys_clk;
	logic             i_rst;
	otp_pkg::t_ip_bus i_ip_bus;
	otp_pkg::t_ip_bus o_ip_bus;
	logic             i_sleep;
	logic             i_read_mode;
	logic             i_write_lock;

	logic [W-1:0] shadow [DEPTH];                               // reference copy of the fuses.
	logic [31:0]  rng_state;
	logic [W-1:0] exp_rdata;
	logic         exp_check;                                    // high for read cycles.
	int           cyc_started;
	int           acks_seen;
	int           data_errs;
	int           proto_errs;
	int           check_errs;

	otp_top #(
		.DEPTH (DEPTH)
	) uut (
		.i_sys_clk    (i_sys_clk),
		.i_rst        (i_rst),
		.i_ip_bus     (i_ip_bus),
		.o_ip_bus     (o_ip_bus),
		.i_sleep      (i_sleep),
		.i_read_mode  (i_read_mode),
		.i_write_lock (i_write_lock)
	);

	initial begin
		i_sys_clk = 1'b0;
		forever #(PERIOD / 2) i_sys_clk = ~i_sys_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// new fuse word after a write ors in the selected bytes unless locked.
	function automatic logic [W-1:0] ref_program(input logic [W-1:0] old,
		input logic [W-1:0] dat, input logic [SW-1:0] sel, input logic lock);
		logic [W-1:0] m;
		for (int b = 0; b < SW; b++) begin
			m[b*8 +: 8] = {8{sel[b]}};
		end
		if (lock) return old;
		return old | (dat & m);
	endfunction

	function automatic logic [W-1:0] ref_read(input int idx);
		if (idx >= DEPTH) return '0;                            // outside the part.
		return shadow[idx];
	endfunction

	function automatic logic [AW-1:0] word_adr(input int idx);
		return AW'(idx * SW);
	endfunction

	// one bus cycle with stb held until ack and cycles counted from stb to the ack sample.
	task automatic bus_cycle(input logic we, input logic [AW-1:0] adr, input logic [W-1:0] dat,
		input logic [SW-1:0] sel, input logic [W-1:0] exp, output int cycles);
		int n;
		n = 0;
		@(negedge i_sys_clk);
		exp_rdata = exp;
		exp_check = !we;
		cyc_started++;
		i_ip_bus.adr = adr;
		i_ip_bus.dat = dat;
		i_ip_bus.sel = sel;
		i_ip_bus.we  = we;
		i_ip_bus.stb = 1'b1;
		do begin
			@(negedge i_sys_clk);
			n++;
		end while (!o_ip_bus.ack);
		i_ip_bus.stb = 1'b0;
		i_ip_bus.we  = 1'b0;
		cycles = n;
	endtask

	task automatic bus_write(input logic [AW-1:0] adr, input logic [W-1:0] dat,
		input logic [SW-1:0] sel, output int cycles);
		int idx;
		idx = int'(adr) / SW;
		bus_cycle(1'b1, adr, dat, sel, '0, cycles);
		if (idx < DEPTH) shadow[idx] = ref_program(shadow[idx], dat, sel, i_write_lock);
	endtask

	task automatic bus_read(input logic [AW-1:0] adr, output int cycles);
		bus_cycle(1'b0, adr, '0, '1, ref_read(int'(adr) / SW), cycles);
	endtask

	task automatic check_oor_latency(input int cycles);
		assert (cycles == OOR_ACK_CYCLES + 1) else begin            // plus the sampling edge.
			$display("Fail time=%0t signal=ack_latency expected=%0d actual=%0d",
				$time, OOR_ACK_CYCLES + 1, cycles);
			check_errs++;
		end
	endtask

	// checks every ack and the read data that comes with it.
	always @(negedge i_sys_clk) begin
		if (o_ip_bus.ack) begin
			assert (acks_seen < cyc_started) else begin
				$display("ack appeared at time %0t with no bus cycle open", $time);
				proto_errs++;
			end
			acks_seen++;
			if (exp_check) begin
				assert (o_ip_bus.dat == exp_rdata) else begin
					$display("Fail time=%0t signal=o_ip_bus.dat expected=%08h actual=%08h",
						$time, exp_rdata, o_ip_bus.dat);
					data_errs++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired after %0d time units, a bus cycle never finished",
			WATCHDOG_TIME);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int           lat;
		int           lat_n;
		int           lat_m;
		int           idx;
		logic [W-1:0] dat;
		logic [SW-1:0] sel;
		i_rst        = 1'b1;
		i_ip_bus     = '0;
		i_sleep      = 1'b0;
		i_read_mode  = 1'b0;
		i_write_lock = 1'b0;
		rng_state    = 32'h1c7a_92c1;
		exp_rdata    = '0;
		exp_check    = 1'b0;
		cyc_started  = 0;
		acks_seen    = 0;
		data_errs    = 0;
		proto_errs   = 0;
		check_errs   = 0;
		for (int i = 0; i < DEPTH; i++) begin
			shadow[i] = '0;                                     // blank part.
		end
		repeat (5) @(negedge i_sys_clk);
		i_rst = 1'b0;

		// blank after reset and no ack without a strobe.
		repeat (5) begin
			@(negedge i_sys_clk);
			assert (!o_ip_bus.ack) else begin
				$display("ack was high after reset with no strobe given");
				check_errs++;
			end
		end
		for (int i = 0; i < DEPTH; i++) bus_read(word_adr(i), lat);

		// random byte masked writes with each one read back.
		for (int i = 0; i < N_RAND; i++) begin
			rng_state = xorshift32(rng_state);
			idx       = int'(rng_state % DEPTH);
			sel       = rng_state[11:8];
			rng_state = xorshift32(rng_state);
			dat       = rng_state;
			bus_write(word_adr(idx), dat, sel, lat);
			bus_read(word_adr(idx), lat);
		end
		bus_write(word_adr(5), 32'hffff_0000, '1, lat);
		bus_write(word_adr(5), '0, '1, lat);                     // zeros clear nothing.
		bus_read(word_adr(5), lat);

		// locked writes are acknowledged but burn nothing.
		i_write_lock = 1'b1;
		for (int i = 0; i < N_LOCK; i++) begin
			rng_state = xorshift32(rng_state);
			bus_write(word_adr(i * 3), rng_state, '1, lat);
			bus_read(word_adr(i * 3), lat);
		end
		i_write_lock = 1'b0;

		// margin reads return the same data and take longer.
		for (int i = 0; i < N_MODE; i++) begin
			idx         = (i * 7) % DEPTH;
			i_read_mode = 1'b0;
			bus_read(word_adr(idx), lat_n);
			i_read_mode = 1'b1;
			bus_read(word_adr(idx), lat_m);
			assert (lat_m > lat_n) else begin
				$display("margin read of word %0d took %0d cycles, not more than normal read %0d",
					idx, lat_m, lat_n);
				check_errs++;
			end
		end
		i_read_mode = 1'b0;

		// sleep holds a read and a write until it drops.
		for (int k = 0; k < 2; k++) begin
			i_sleep = 1'b1;
			fork
				if (k == 0) bus_read(word_adr(3), lat);
				else bus_write(word_adr(9), 32'h0f0f_5a5a, 4'b1011, lat);
				begin
					repeat (SLEEP_CYCLES) begin
						@(negedge i_sys_clk);
						assert (!o_ip_bus.ack) else begin
							$display("ack appeared while i_sleep was high");
							check_errs++;
						end
					end
					i_sleep = 1'b0;
				end
			join
			assert (lat > SLEEP_CYCLES) else begin
				$display("bus cycle finished in %0d cycles, before sleep dropped", lat);
				check_errs++;
			end
		end
		bus_read(word_adr(9), lat);

		// out of range cycles ack with zero data and change nothing in range.
		bus_read(16'h0100, lat);
		check_oor_latency(lat);
		bus_write(16'h0100, '1, '1, lat);
		check_oor_latency(lat);
		bus_write(16'hfffc, '1, '1, lat);
		check_oor_latency(lat);
		bus_read(16'hfffc, lat);
		check_oor_latency(lat);
		for (int i = 0; i < DEPTH; i++) bus_read(word_adr(i), lat);

		repeat (4) @(negedge i_sys_clk);
		$display("errors: data=%0d protocol=%0d checks=%0d, %0d bus cycles, %0d acks",
			data_errs, proto_errs, check_errs, cyc_started, acks_seen);
		if (data_errs + proto_errs + check_errs == 0 && acks_seen == cyc_started) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
verilog/otp_pkg.sv
verilog/otp_bus_slave.sv
verilog/otp_ctrl.sv
verilog/otp_array.sv
verilog/otp_top.sv
test/otp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = otp_tb
FILELIST  = project.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation FAILED
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# a crash or the fail message in the log fails the target.
sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
